//--- Makefile
VERILATOR  = verilator
TOP        = uart_alu_tb
FILE_LIST  = list.f
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "TEST PASS" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- include/uart_alu_defines.svh
`ifndef UART_ALU_DEFINES_SVH
`define UART_ALU_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Data path sizes.
////////////////////////////////////////////////////////////////////////////

// Operands, result and serial word.
`define DATA_WIDTH      8

`define OPCODE_WIDTH    8       // Opcode byte.

////////////////////////////////////////////////////////////////////////////
// Serial timing.
////////////////////////////////////////////////////////////////////////////

// Clocks per oversampling tick, kept small for simulation.
`define BAUD_DIVISOR    4

`define OVERSAMPLE      16      // Ticks per bit.

`endif

//--- list.f
+incdir+include
logic/alu_pkg.sv
logic/uart_pkg.sv
logic/baud_tick_gen.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/alu.sv
logic/interface_circuit.sv
logic/uart_alu_top.sv
tb/uart_alu_tb.sv

//--- logic/alu.sv
module alu (
    input  alu_pkg::operand_t i_operand_a,
    input  alu_pkg::operand_t i_operand_b,
    input  alu_pkg::opcode_t  i_opcode,
    output alu_pkg::result_t  o_result
);

    import alu_pkg::*;

    ////////////////////////////////////////////////////////////////////////
    // Opcode decode.
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (alu_op_e'(i_opcode))
            ADD: begin
                o_result = i_operand_a + i_operand_b;     // Wraps at 8 bits.
            end
            SUB: begin
                o_result = i_operand_a - i_operand_b;
            end
            AND: begin
                o_result = i_operand_a & i_operand_b;
            end
            OR: begin
                o_result = i_operand_a | i_operand_b;
            end
            XOR: begin
                o_result = i_operand_a ^ i_operand_b;
            end
            NOR: begin
                o_result = ~(i_operand_a | i_operand_b);
            end
            SRL: begin
                o_result = i_operand_a >> i_operand_b;
            end
            // Sign bit copied in from the left.
            SRA: begin
                o_result = result_t'($signed(i_operand_a) >>> i_operand_b);
            end
            default: begin
                o_result = '0;                            // Unknown opcode.
            end
        endcase
    end

endmodule

//--- logic/alu_pkg.sv
`include "uart_alu_defines.svh"

package alu_pkg;

    ////////////////////////////////////////////////////////////////////////
    // ALU data types.
    ////////////////////////////////////////////////////////////////////////

    typedef logic [`DATA_WIDTH-1:0]   operand_t;    // One ALU input.
    typedef logic [`DATA_WIDTH-1:0]   result_t;
    typedef logic [`OPCODE_WIDTH-1:0] opcode_t;     // Raw byte from the host.

    // Opcodes as sent on the serial line.
    typedef enum opcode_t {
        ADD = 8'h20,
        SUB = 8'h22,
        AND = 8'h24,
        OR  = 8'h25,
        XOR = 8'h26,
        NOR = 8'h27,
        SRL = 8'h02,    // Logical shift right.
        SRA = 8'h03     // Arithmetic shift right.
    } alu_op_e;

endpackage

//--- logic/baud_tick_gen.sv
`include "uart_alu_defines.svh"

module baud_tick_gen (
    input  logic i_clock,
    input  logic i_reset,
    output logic o_tick
);

    import uart_pkg::*;

    baud_count_t count;
    logic        wrap;

    assign wrap = (count == baud_count_t'(`BAUD_DIVISOR - 1));

    // Free running, shared by receiver and transmitter.
    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            count  <= '0;
            o_tick <= 1'b0;
        end else begin
            o_tick <= wrap;                 // One clock wide.
            if (wrap) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

//--- logic/interface_circuit.sv
module interface_circuit (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  logic                 i_rx_done,
    input  uart_pkg::uart_word_t i_rx_data,
    input  alu_pkg::result_t     i_result,
    input  logic                 i_tx_done,
    output alu_pkg::operand_t    o_operand_a,
    output alu_pkg::operand_t    o_operand_b,
    output alu_pkg::opcode_t     o_opcode,
    output logic                 o_tx_start,
    output uart_pkg::uart_word_t o_tx_data
);

    import uart_pkg::*;

    intf_state_e state;

    ////////////////////////////////////////////////////////////////////////
    // Command sequencer and ALU registers.
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state       <= WAIT_A;
            o_operand_a <= '0;
            o_operand_b <= '0;
            o_opcode    <= '0;
            o_tx_start  <= 1'b0;
            o_tx_data   <= '0;
        end else begin
            o_tx_start <= 1'b0;
            case (state)
                WAIT_A: begin
                    if (i_rx_done) begin
                        o_operand_a <= i_rx_data;
                        state       <= WAIT_OP;
                    end
                end
                WAIT_OP: begin
                    if (i_rx_done) begin
                        o_opcode <= i_rx_data;
                        state    <= WAIT_B;
                    end
                end
                WAIT_B: begin
                    if (i_rx_done) begin
                        o_operand_b <= i_rx_data;
                        state       <= SEND;
                    end
                end
                // ALU output already reflects the new B here.
                SEND: begin
                    o_tx_start <= 1'b1;
                    o_tx_data  <= i_result;
                    state      <= WAIT_TX;
                end
                WAIT_TX: begin
                    if (i_tx_done) begin                // Bytes seen meanwhile are lost.
                        state <= WAIT_A;
                    end
                end
                default: state <= WAIT_A;
            endcase
        end
    end

endmodule

//--- logic/uart_alu_top.sv
module uart_alu_top (
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_rx,
    output logic o_tx
);

    import uart_pkg::*;
    import alu_pkg::*;

    logic       tick;
    uart_word_t rx_data;
    logic       rx_done;
    operand_t   operand_a;
    operand_t   operand_b;
    opcode_t    opcode;
    result_t    result;
    logic       tx_start;
    uart_word_t tx_data;
    logic       tx_done;

    baud_tick_gen i_baud_tick_gen (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .o_tick  (tick)
    );

    uart_rx i_uart_rx (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_tick    (tick),
        .i_rx      (i_rx),
        .o_rx_data (rx_data),
        .o_rx_done (rx_done)
    );

    // Register block that steers the ALU.
    interface_circuit i_interface_circuit (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_rx_done   (rx_done),
        .i_rx_data   (rx_data),
        .i_result    (result),
        .i_tx_done   (tx_done),
        .o_operand_a (operand_a),
        .o_operand_b (operand_b),
        .o_opcode    (opcode),
        .o_tx_start  (tx_start),
        .o_tx_data   (tx_data)
    );

    alu i_alu (
        .i_operand_a (operand_a),
        .i_operand_b (operand_b),
        .i_opcode    (opcode),
        .o_result    (result)
    );

    uart_tx i_uart_tx (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_tick     (tick),
        .i_tx_start (tx_start),
        .i_tx_data  (tx_data),
        .o_tx       (o_tx),
        .o_tx_done  (tx_done)
    );

endmodule

//--- logic/uart_pkg.sv
`include "uart_alu_defines.svh"

package uart_pkg;

    typedef logic [`DATA_WIDTH-1:0]            uart_word_t;   // One data byte.

    // Counter widths for the serial timing.
    typedef logic [$clog2(`BAUD_DIVISOR)-1:0] baud_count_t;
    typedef logic [$clog2(`OVERSAMPLE)-1:0]   tick_count_t;
    typedef logic [$clog2(`DATA_WIDTH)-1:0]   bit_count_t;

    ////////////////////////////////////////////////////////////////////////
    // State machines.
    ////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

    // Command sequence: A, opcode, B, then the reply.
    typedef enum logic [2:0] {
        WAIT_A,
        WAIT_OP,
        WAIT_B,
        SEND,
        WAIT_TX
    } intf_state_e;

endpackage

//--- logic/uart_rx.sv
`include "uart_alu_defines.svh"

module uart_rx (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  logic                 i_tick,
    input  logic                 i_rx,
    output uart_pkg::uart_word_t o_rx_data,
    output logic                 o_rx_done
);

    import uart_pkg::*;

    logic        rx_meta;
    logic        rx_sync;
    rx_state_e   state;
    tick_count_t tick_count;
    bit_count_t  bit_count;
    uart_word_t  shift_reg;
    logic        half_bit;
    logic        full_bit;
    logic        sample_data;

    // Two flops against metastability. Line idles high.
    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
        end
    end

    assign half_bit    = i_tick && (tick_count == tick_count_t'(`OVERSAMPLE / 2 - 1));
    assign full_bit    = i_tick && (tick_count == tick_count_t'(`OVERSAMPLE - 1));
    assign sample_data = (state == RX_DATA) && full_bit;

    ////////////////////////////////////////////////////////////////////////
    // Frame FSM.
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state      <= RX_IDLE;
            tick_count <= '0;
            bit_count  <= '0;
            o_rx_done  <= 1'b0;
        end else begin
            o_rx_done <= 1'b0;
            if (i_tick) begin
                tick_count <= tick_count + 1'b1;
            end
            case (state)
                RX_IDLE: begin
                    tick_count <= '0;
                    if (!rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (half_bit) begin           // Middle of the start bit.
                        tick_count <= '0;
                        bit_count  <= '0;
                        state      <= rx_sync ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (full_bit) begin
                        if (bit_count == bit_count_t'(`DATA_WIDTH - 1)) begin
                            state <= RX_STOP;
                        end else begin
                            bit_count <= bit_count + 1'b1;
                        end
                    end
                end
                RX_STOP: begin
                    if (full_bit) begin
                        o_rx_done <= rx_sync;     // Low stop bit drops the frame.
                        state     <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first.
    always_ff @(posedge i_clock) begin
        if (sample_data) begin
            shift_reg <= {rx_sync, shift_reg[`DATA_WIDTH-1:1]};
        end
    end

    assign o_rx_data = shift_reg;

endmodule

//--- logic/uart_tx.sv
`include "uart_alu_defines.svh"

module uart_tx (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  logic                 i_tick,
    input  logic                 i_tx_start,
    input  uart_pkg::uart_word_t i_tx_data,
    output logic                 o_tx,
    output logic                 o_tx_done
);

    import uart_pkg::*;

    tx_state_e   state;
    tick_count_t tick_count;
    bit_count_t  bit_count;
    uart_word_t  shift_reg;
    logic        bit_end;
    logic        last_bit;

    assign bit_end  = i_tick && (tick_count == tick_count_t'(`OVERSAMPLE - 1));
    assign last_bit = (bit_count == bit_count_t'(`DATA_WIDTH - 1));

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state      <= TX_IDLE;
            tick_count <= '0;
            bit_count  <= '0;
            o_tx       <= 1'b1;
            o_tx_done  <= 1'b0;
        end else begin
            o_tx_done <= 1'b0;
            if (i_tick) begin
                tick_count <= tick_count + 1'b1;
            end
            case (state)
                TX_IDLE: begin
                    tick_count <= '0;
                    bit_count  <= '0;
                    if (i_tx_start) begin
                        o_tx  <= 1'b0;            // Start bit.
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        o_tx  <= shift_reg[0];
                        state <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (last_bit) begin
                            o_tx  <= 1'b1;        // Stop bit.
                            state <= TX_STOP;
                        end else begin
                            o_tx      <= shift_reg[1];
                            bit_count <= bit_count + 1'b1;
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        o_tx_done <= 1'b1;
                        state     <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Byte latched on start, then moved down one bit per data bit.
    always_ff @(posedge i_clock) begin
        if (state == TX_IDLE && i_tx_start) begin
            shift_reg <= i_tx_data;
        end else if (state == TX_DATA && bit_end) begin
            shift_reg <= shift_reg >> 1;
        end
    end

endmodule

//--- tb/uart_alu_tb.sv
module uart_alu_tb;

    localparam int CLOCK_PERIOD = 100;
    localparam int DRIVE_DELAY  = 10;
    localparam int BIT_CLOCKS   = 64;       // 4 clocks per tick, 16 ticks per bit.
    localparam int NUM_FIXED    = 14;
    localparam int NUM_RANDOM   = 4;
    localparam int NUM_ENTRIES  = NUM_FIXED + NUM_RANDOM;
    localparam int TIMEOUT      = NUM_ENTRIES * 4 * 10 * BIT_CLOCKS * CLOCK_PERIOD * 2;

    logic i_clock;
    logic i_reset;
    logic i_rx;
    logic o_tx;

    // Command table.
    string      test_name [NUM_ENTRIES];
    logic [7:0] operand_a [NUM_ENTRIES];
    logic [7:0] opcode    [NUM_ENTRIES];
    logic [7:0] operand_b [NUM_ENTRIES];
    logic [7:0] expected  [NUM_ENTRIES];
    logic       bad_lead  [NUM_ENTRIES];    // Bad frame sent ahead of A.

    logic [31:0] lcg_state;
    int          error_count;

    uart_alu_top i_uart_alu_top (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_rx    (i_rx),
        .o_tx    (o_tx)
    );

    initial begin
        i_clock = 1'b0;
        forever begin
            #(CLOCK_PERIOD / 2) i_clock = ~i_clock;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and stimulus helpers.
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Result worked out bit by bit from the opcode rules.
    function automatic logic [7:0] expected_result(input logic [7:0] a, input logic [7:0] op,
                                                   input logic [7:0] b);
        logic [7:0] r;
        int         n;
        case (op)
            8'h20: r = a + b;
            8'h22: r = a - b;
            8'h24: r = a & b;
            8'h25: r = a | b;
            8'h26: r = a ^ b;
            8'h27: r = ~(a | b);
            8'h02, 8'h03: begin
                r = a;
                for (n = 0; n < b; n++) begin
                    r = {(op == 8'h03) ? a[7] : 1'b0, r[7:1]};  // Fill from the left.
                end
            end
            default: r = 8'h00;
        endcase
        return r;
    endfunction

    task automatic set_entry(input int idx, input string name, input logic [7:0] a,
                             input logic [7:0] op, input logic [7:0] b,
                             input logic [7:0] result, input logic bad);
        test_name[idx] = name;
        operand_a[idx] = a;
        opcode[idx]    = op;
        operand_b[idx] = b;
        expected[idx]  = result;
        bad_lead[idx]  = bad;
    endtask

    task automatic load_table();
        set_entry(0,  "add_basic",     8'h12, 8'h20, 8'h34, 8'h46, 1'b0);
        set_entry(1,  "add_wrap",      8'hF0, 8'h20, 8'h20, 8'h10, 1'b0);
        set_entry(2,  "sub_basic",     8'h50, 8'h22, 8'h13, 8'h3D, 1'b0);
        set_entry(3,  "sub_wrap",      8'h01, 8'h22, 8'h02, 8'hFF, 1'b0);
        set_entry(4,  "and_bits",      8'hCC, 8'h24, 8'hAA, 8'h88, 1'b0);
        set_entry(5,  "or_bits",       8'hC0, 8'h25, 8'h0A, 8'hCA, 1'b0);
        set_entry(6,  "xor_bits",      8'hFF, 8'h26, 8'h5A, 8'hA5, 1'b0);
        set_entry(7,  "nor_bits",      8'h0F, 8'h27, 8'h30, 8'hC0, 1'b0);
        set_entry(8,  "srl_three",     8'h80, 8'h02, 8'h03, 8'h10, 1'b0);
        set_entry(9,  "sra_sign",      8'h80, 8'h03, 8'h03, 8'hF0, 1'b0);
        set_entry(10, "sra_positive",  8'h74, 8'h03, 8'h02, 8'h1D, 1'b0);
        set_entry(11, "undefined_op",  8'h5A, 8'h99, 8'h3C, 8'h00, 1'b0);
        set_entry(12, "and_fresh",     8'hF3, 8'h24, 8'h3F, 8'h33, 1'b0);
        set_entry(13, "framing_error", 8'h21, 8'h20, 8'h11, 8'h32, 1'b1);
    endtask

    task automatic add_random_entries();
        logic [7:0]  ops [8];
        logic [31:0] word;
        logic [7:0]  a;
        logic [7:0]  op;
        logic [7:0]  b;
        int          i;
        ops = '{8'h20, 8'h22, 8'h24, 8'h25, 8'h26, 8'h27, 8'h02, 8'h03};
        for (i = 0; i < NUM_RANDOM; i++) begin
            word = next_random();
            a    = word[23:16];
            op   = ops[word[26:24]];
            word = next_random();
            b    = word[23:16];
            if (op == 8'h02 || op == 8'h03) begin
                b = {5'b0, b[2:0]};                 // Keep shifts inside the byte.
            end
            set_entry(NUM_FIXED + i, $sformatf("random_%0d", i), a, op, b,
                      expected_result(a, op, b), 1'b0);
        end
    endtask

    // Ends a small delay after a rising edge.
    task automatic wait_clocks(input int count);
        repeat (count) @(posedge i_clock);
        #(DRIVE_DELAY);
    endtask

    task automatic send_frame(input logic [7:0] data, input logic bad_stop);
        int i;
        i_rx = 1'b0;
        wait_clocks(BIT_CLOCKS);
        for (i = 0; i < 8; i++) begin
            i_rx = data[i];
            wait_clocks(BIT_CLOCKS);
        end
        i_rx = bad_stop ? 1'b0 : 1'b1;
        if (bad_stop) begin
            // Low through the mid-bit sample, then idle long enough to resync.
            wait_clocks(BIT_CLOCKS * 3 / 4);
            i_rx = 1'b1;
            wait_clocks(BIT_CLOCKS / 4 + 2 * BIT_CLOCKS);
        end else begin
            wait_clocks(BIT_CLOCKS);
        end
    endtask

    // Samples on falling clock edges, away from the DUT's updates.
    task automatic receive_frame(output logic [7:0] data);
        int i;
        @(negedge o_tx);
        repeat (BIT_CLOCKS / 2) @(negedge i_clock);
        if (o_tx !== 1'b0) begin
            $display("Reply start bit did not stay low until mid-bit at %0t", $time);
            error_count++;
        end
        for (i = 0; i < 8; i++) begin
            repeat (BIT_CLOCKS) @(negedge i_clock);
            data[i] = o_tx;
        end
        repeat (BIT_CLOCKS) @(negedge i_clock);
        if (o_tx !== 1'b1) begin
            $display("Reply stop bit was low at %0t", $time);
            error_count++;
        end
    endtask

    task automatic expect_idle(input int bits, input string phase_name);
        logic seen_low;
        int   i;
        seen_low = 1'b0;
        for (i = 0; i < bits * BIT_CLOCKS; i++) begin
            @(negedge i_clock);
            if (o_tx !== 1'b1) begin
                seen_low = 1'b1;
            end
        end
        if (seen_low) begin
            $display("Serial output left idle when no reply was due, during %s", phase_name);
            error_count++;
        end
        wait_clocks(1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence.
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [7:0] reply;
        int         idx;
        i_reset     = 1'b0;
        i_rx        = 1'b1;
        error_count = 0;
        lcg_state   = 32'h27e5_6e8a;
        load_table();
        add_random_entries();
        wait_clocks(2);
        i_reset = 1'b1;

        if (o_tx !== 1'b1) begin
            $display("Serial output was not high right after reset");
            error_count++;
        end
        expect_idle(20, "idle after reset");

        for (idx = 0; idx < NUM_ENTRIES; idx++) begin
            fork
                begin
                    if (bad_lead[idx]) begin
                        send_frame(8'hEE, 1'b1);
                    end
                    send_frame(operand_a[idx], 1'b0);
                    send_frame(opcode[idx], 1'b0);
                    send_frame(operand_b[idx], 1'b0);
                end
                receive_frame(reply);
            join
            if (reply !== expected[idx]) begin
                $display("Error %s: expected 8'h%02h, actual 8'h%02h",
                         test_name[idx], expected[idx], reply);
                error_count++;
            end
            expect_idle(3, test_name[idx]);     // Exactly one reply.
        end

        $display("Ran %0d commands with %0d errors", NUM_ENTRIES, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("Run timed out at %0t before the command table finished", $time);
        $display("TEST FAIL");
        $finish;
    end

endmodule
